//--- dv/banked_scratchpad_trace.txt
# columns: test op(W write, R read, I idle) addr(hex word) mask(hex) data(hex) expected(hex)
# expected is only used on R lines, addr bit 0 picks the bank
wr_rd_banks W 00 ffffffff 11111111 00000000
wr_rd_banks W 01 ffffffff 22222222 00000000
wr_rd_banks W 02 ffffffff 33333333 00000000
wr_rd_banks W 03 ffffffff 44444444 00000000
wr_rd_banks W 7e ffffffff a5a5a5a5 00000000
wr_rd_banks W 7f ffffffff 5a5a5a5a 00000000
wr_rd_banks W 40 ffffffff deadbeef 00000000
wr_rd_banks W 41 ffffffff cafef00d 00000000
wr_rd_banks R 00 00000000 00000000 11111111
wr_rd_banks R 01 00000000 00000000 22222222
wr_rd_banks R 02 00000000 00000000 33333333
wr_rd_banks R 03 00000000 00000000 44444444
wr_rd_banks R 7f 00000000 00000000 5a5a5a5a
wr_rd_banks R 7e 00000000 00000000 a5a5a5a5
wr_rd_banks R 41 00000000 00000000 cafef00d
wr_rd_banks R 40 00000000 00000000 deadbeef
wr_rd_banks R 01 00000000 00000000 22222222
wr_rd_banks R 00 00000000 00000000 11111111
bit_mask W 10 ffffffff ffffffff 00000000
bit_mask W 10 0000ffff 12345678 00000000
bit_mask R 10 00000000 00000000 ffff5678
bit_mask W 11 ffffffff ffffffff 00000000
bit_mask W 11 f0f0f0f0 00000000 00000000
bit_mask R 11 00000000 00000000 0f0f0f0f
bit_mask W 11 00000001 00000000 00000000
bit_mask R 11 00000000 00000000 0f0f0f0e
bit_mask W 12 ffffffff 00000000 00000000
bit_mask W 12 80000001 ffffffff 00000000
bit_mask R 12 00000000 00000000 80000001
bit_mask W 12 00000000 ffffffff 00000000
bit_mask R 12 00000000 00000000 80000001
bit_mask W 13 ffffffff ffffffff 00000000
bit_mask W 13 ff00ff00 00ff00ff 00000000
bit_mask R 13 00000000 00000000 00ff00ff
bit_mask W 13 0000ff00 0000aa00 00000000
bit_mask R 13 00000000 00000000 00ffaaff
bit_mask R 10 00000000 00000000 ffff5678
hold_data W 20 ffffffff 0badc0de 00000000
hold_data W 21 ffffffff 600dd00d 00000000
hold_data W 22 ffffffff 01234567 00000000
hold_data R 20 00000000 00000000 0badc0de
hold_data I 00 00000000 00000000 00000000
hold_data I 00 00000000 00000000 00000000
hold_data W 21 ffffffff 11112222 00000000
hold_data W 23 ffffffff 33334444 00000000
hold_data W 20 ffffffff 77778888 00000000
hold_data I 00 00000000 00000000 00000000
hold_data R 20 00000000 00000000 77778888
hold_data R 21 00000000 00000000 11112222
hold_data I 00 00000000 00000000 00000000
hold_data W 21 ffffffff 99990000 00000000
hold_data W 22 ffffffff aaaa5555 00000000
hold_data I 00 00000000 00000000 00000000
hold_data R 21 00000000 00000000 99990000
hold_data R 23 00000000 00000000 33334444
hold_data R 22 00000000 00000000 aaaa5555
rd_strobe R 00 00000000 00000000 11111111
rd_strobe R 01 00000000 00000000 22222222
rd_strobe R 02 00000000 00000000 33333333
rd_strobe I 00 00000000 00000000 00000000
rd_strobe W 30 ffffffff 13579bdf 00000000
rd_strobe W 31 ffffffff 2468ace0 00000000
rd_strobe R 31 00000000 00000000 2468ace0
rd_strobe R 30 00000000 00000000 13579bdf
rd_strobe I 00 00000000 00000000 00000000
rd_strobe I 00 00000000 00000000 00000000
rd_strobe R 7f 00000000 00000000 5a5a5a5a
rd_strobe W 7e ffffffff 0f1e2d3c 00000000
rd_strobe R 7e 00000000 00000000 0f1e2d3c
rd_strobe R 40 00000000 00000000 deadbeef

//--- banked_scratchpad.f
common/banked_scratchpad_pkg.sv
hw/sp_ram/sp_ram.sv
hw/bank_ctrl.sv
hw/banked_scratchpad.sv
dv/banked_scratchpad_tb.sv

//--- dv/banked_scratchpad_tb.sv
/*
 * banked_scratchpad_tb: trace driven testbench for the two-bank scratchpad
 * Replays host accesses from the trace and checks read data, strobe timing and data hold.
 */

`timescale 1ns/10ps

module banked_scratchpad_tb;

   localparam int    DW         = banked_scratchpad_pkg::DATA_W;
   localparam int    AW         = banked_scratchpad_pkg::ADDR_W;
   localparam string TRACE_PATH = "dv/banked_scratchpad_trace.txt";
   localparam int    CLK_HALF   = 4;       // 8 ns period
   localparam int    RST_CYCLES = 10;
   localparam int    MAX_GAP    = 3;       // most idle cycles after a trace line
   localparam int    SEED       = 69;

   logic          clk;
   logic          rst_n;
   logic          ce;
   logic          we;
   logic [DW-1:0] wmask;
   logic [AW-1:0] addr;
   logic [DW-1:0] din;
   logic [DW-1:0] rdata;
   logic          rvalid;

   // one entry per trace access line
   string         tr_name[$];
   string         tr_op[$];
   logic [AW-1:0] tr_addr[$];
   logic [DW-1:0] tr_mask[$];
   logic [DW-1:0] tr_data[$];
   logic [DW-1:0] tr_exp[$];

   // outstanding reads in issue order
   logic [DW-1:0] exp_q[$];
   int            test_q[$];               // test index of each read
   int            due_q[$];                // cycle where rvalid must show

   // per test bookkeeping
   string test_names[$];
   int    test_pass[$];
   int    test_fail[$];
   int    cur_test   = 0;
   int    total_pass = 0;
   int    total_fail = 0;

   int cyc       = 0;                      // rising edges seen
   int cyc_limit = 0;                      // set once the trace is loaded

   // expected hold of rdata between reads
   logic [DW-1:0] last_word = '0;          // rdata at the last rvalid pulse
   logic          have_last = 1'b0;
   logic          hold_ok   = 1'b0;        // no access has disturbed the tagged bank
   logic [AW-1:0] rd_addr   = '0;          // address of the newest read driven
   logic          rewrote   = 1'b0;        // newest read word already rewritten once

   banked_scratchpad i_dut (
      .clk    (clk),
      .rst_n  (rst_n),
      .ce     (ce),
      .we     (we),
      .wmask  (wmask),
      .addr   (addr),
      .din    (din),
      .rdata  (rdata),
      .rvalid (rvalid)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // watchdog limit scales with trace length
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc_limit > 0 && cyc >= cyc_limit) begin
         $display("timeout after %0d cycles, the trace did not complete", cyc);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   task automatic record_pass(input int idx);
      test_pass[idx] = test_pass[idx] + 1;
      total_pass++;
   endtask

   task automatic record_fail(input int idx);
      test_fail[idx] = test_fail[idx] + 1;
      total_fail++;
   endtask

   task automatic start_test(input string name);
      test_names.push_back(name);
      test_pass.push_back(0);
      test_fail.push_back(0);
      cur_test = test_names.size() - 1;
   endtask

   // host port goes quiet for one cycle
   task automatic idle_cycle();
      @(posedge clk);
      #1;
      ce    = 1'b0;
      we    = 1'b0;
      wmask = '0;
      din   = '0;
   endtask

   // let outstanding reads return before reporting the test
   task automatic finish_test(input int idx);
      idle_cycle();
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      $display("test %-14s %s  pass=%0d fail=%0d", test_names[idx],
               (test_fail[idx] == 0) ? "ok  " : "BAD ", test_pass[idx], test_fail[idx]);
   endtask

   // a write can move the output register of the tagged bank
   task automatic note_write(input logic [AW-1:0] wr_addr);
      if (hold_ok && wr_addr[0] == rd_addr[0]) begin
         if (wr_addr == rd_addr && !rewrote) begin
            rewrote = 1'b1;                // register captures the word just read
         end else begin
            hold_ok = 1'b0;                // register now shows another old word
         end
      end
   endtask

   task automatic load_trace();
      int          fd;
      int          n;
      int          line_no;
      string       line;
      string       f_name;
      string       f_op;
      logic [31:0] f_addr;
      logic [31:0] f_mask;
      logic [31:0] f_data;
      logic [31:0] f_exp;
      line_no = 0;
      fd = $fopen(TRACE_PATH, "r");
      if (fd == 0) begin
         $display("cannot open the trace file %s", TRACE_PATH);
         record_fail(cur_test);
      end else begin
         while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
               n = $sscanf(line, "%s %s %h %h %h %h",
                           f_name, f_op, f_addr, f_mask, f_data, f_exp);
               if (n != 6) begin
                  $display("trace line %0d does not have six fields", line_no);
                  record_fail(cur_test);
               end else if (f_addr >= (1 << AW)) begin
                  $display("trace line %0d addresses a word past the memory", line_no);
                  record_fail(cur_test);
               end else begin
                  tr_name.push_back(f_name);
                  tr_op.push_back(f_op);
                  tr_addr.push_back(f_addr[AW-1:0]);
                  tr_mask.push_back(f_mask[DW-1:0]);
                  tr_data.push_back(f_data[DW-1:0]);
                  tr_exp.push_back(f_exp[DW-1:0]);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // one trace access applied 1 ns after the edge
   task automatic drive_line(input int i);
      @(posedge clk);
      #1;
      if (tr_op[i] == "W") begin
         ce    = 1'b1;
         we    = 1'b1;
         wmask = tr_mask[i];
         addr  = tr_addr[i];
         din   = tr_data[i];
         note_write(tr_addr[i]);
      end else if (tr_op[i] == "R") begin
         ce    = 1'b1;
         we    = 1'b0;
         wmask = '0;
         addr  = tr_addr[i];
         din   = '0;
         exp_q.push_back(tr_exp[i]);
         test_q.push_back(cur_test);
         due_q.push_back(cyc + 1);         // valid in the cycle after the accepting edge
         hold_ok = 1'b1;
         rd_addr = tr_addr[i];
         rewrote = 1'b0;
      end else if (tr_op[i] == "I") begin
         ce = 1'b0;
         we = 1'b0;
      end else begin
         $display("trace entry %0d has an unknown operation %s", i, tr_op[i]);
         record_fail(cur_test);
         ce = 1'b0;
         we = 1'b0;
      end
   endtask

   // response monitor sampling mid cycle
   always @(negedge clk) begin
      logic [DW-1:0] exp_word;
      int            t;
      int            due;
      if (!rst_n) begin
         assert (rvalid === 1'b0) record_pass(0);
         else begin
            $display("rvalid went high while reset was asserted, cycle %0d", cyc);
            record_fail(0);
         end
      end else if (rvalid === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("rvalid pulsed at cycle %0d with no read outstanding", cyc);
            record_fail(cur_test);
         end else begin
            exp_word = exp_q.pop_front();
            t        = test_q.pop_front();
            due      = due_q.pop_front();
            assert (due == cyc) record_pass(t);
            else begin
               $display("ERR %s rvalid cycle expected %0d actual %0d", test_names[t], due, cyc);
               record_fail(t);
            end
            assert (rdata === exp_word) record_pass(t);
            else begin
               $display("ERR %s expected %h actual %h", test_names[t], exp_word, rdata);
               record_fail(t);
            end
            last_word = rdata;             // reference for the hold check
            have_last = 1'b1;
         end
      end else begin
         assert (rvalid === 1'b0)
         else begin
            $display("rvalid is unknown at cycle %0d", cyc);
            record_fail(cur_test);
         end
         if (exp_q.size() != 0) begin
            assert (due_q[0] > cyc)
            else begin
               t        = test_q.pop_front();
               exp_word = exp_q.pop_front();
               due      = due_q.pop_front();
               $display("read in test %s got no rvalid pulse by cycle %0d", test_names[t], cyc);
               record_fail(t);
            end
         end else if (have_last && hold_ok) begin
            assert (rdata === last_word)
            else begin
               $display("ERR %s held rdata expected %h actual %h",
                        test_names[cur_test], last_word, rdata);
               record_fail(cur_test);
            end
         end
      end
   end

   initial begin
      int unsigned gap;
      void'($urandom(SEED));               // seeds every later gap draw
      ce        = 1'b0;
      we        = 1'b0;
      wmask     = '0;
      addr      = '0;
      din       = '0;
      rst_n     = 1'b0;
      start_test("reset_state");
      load_trace();
      cyc_limit = tr_name.size() * 5 + 100;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      repeat (3) idle_cycle();             // strobe must stay quiet before any read
      for (int i = 0; i < tr_name.size(); i++) begin
         if (tr_name[i] != test_names[cur_test]) begin
            finish_test(cur_test);
            start_test(tr_name[i]);
         end
         drive_line(i);
         gap = $urandom % (MAX_GAP + 1);
         repeat (gap) idle_cycle();
      end
      finish_test(cur_test);
      if (tr_name.size() == 0) begin
         $display("the trace holds no accesses");
         record_fail(0);
      end
      $display("summary: pass=%0d fail=%0d over %0d tests", total_pass, total_fail,
               test_names.size());
      if (total_fail == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- hw/banked_scratchpad.sv
/*
 * banked_scratchpad: two-bank interleaved scratchpad memory
 * Host port fans out through bank_ctrl to two sp_ram banks; read data returns one cycle later.
 */

`timescale 1ns/10ps

module banked_scratchpad (
   input  logic                                       clk,
   input  logic                                       rst_n,
   input  logic                                       ce,       // access strobe
   input  logic                                       we,       // 1 = write, 0 = read
   input  logic [banked_scratchpad_pkg::DATA_W-1:0]   wmask,    // per bit write mask
   input  logic [banked_scratchpad_pkg::ADDR_W-1:0]   addr,     // word address, bit 0 = bank
   input  logic [banked_scratchpad_pkg::DATA_W-1:0]   din,      // write data
   output logic [banked_scratchpad_pkg::DATA_W-1:0]   rdata,    // read data
   output logic                                       rvalid    // read data valid
);

   logic                                       bank0_ce;     // even word access
   logic                                       bank1_ce;     // odd word access
   logic [banked_scratchpad_pkg::BANK_AW-1:0]  bank_addr;    // in-bank word address
   logic [banked_scratchpad_pkg::DATA_W-1:0]   bank0_dout;
   logic [banked_scratchpad_pkg::DATA_W-1:0]   bank1_dout;

   // decode and read steering
   bank_ctrl i_bank_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .ce         (ce),
      .we         (we),
      .addr       (addr),
      .bank0_ce   (bank0_ce),
      .bank1_ce   (bank1_ce),
      .bank_addr  (bank_addr),
      .bank0_dout (bank0_dout),
      .bank1_dout (bank1_dout),
      .rdata      (rdata),
      .rvalid     (rvalid)
   );

   // bank 0, even host addresses
   sp_ram #(
      .DW    (banked_scratchpad_pkg::DATA_W),
      .DEPTH (banked_scratchpad_pkg::BANK_DEPTH),
      .REG   (banked_scratchpad_pkg::RAM_REG)
   ) i_bank0 (
      .clk   (clk),
      .ce    (bank0_ce),
      .we    (we),           // shared write enable
      .wmask (wmask),
      .addr  (bank_addr),
      .din   (din),
      .dout  (bank0_dout)
   );

   // bank 1, odd host addresses
   sp_ram #(
      .DW    (banked_scratchpad_pkg::DATA_W),
      .DEPTH (banked_scratchpad_pkg::BANK_DEPTH),
      .REG   (banked_scratchpad_pkg::RAM_REG)
   ) i_bank1 (
      .clk   (clk),
      .ce    (bank1_ce),
      .we    (we),
      .wmask (wmask),
      .addr  (bank_addr),
      .din   (din),
      .dout  (bank1_dout)
   );

endmodule

//--- hw/bank_ctrl.sv
/*
 * bank_ctrl: two-bank access steering for the scratchpad
 * Decodes the host address into bank enables and steers read data with a valid strobe.
 */

`timescale 1ns/10ps

module bank_ctrl (
   input  logic                                       clk,
   input  logic                                       rst_n,
   // host side
   input  logic                                       ce,          // access strobe
   input  logic                                       we,          // 1 = write, 0 = read
   input  logic [banked_scratchpad_pkg::ADDR_W-1:0]   addr,        // host word address
   // bank side
   output logic                                       bank0_ce,    // even words
   output logic                                       bank1_ce,    // odd words
   output logic [banked_scratchpad_pkg::BANK_AW-1:0]  bank_addr,   // shared by both banks
   input  logic [banked_scratchpad_pkg::DATA_W-1:0]   bank0_dout,
   input  logic [banked_scratchpad_pkg::DATA_W-1:0]   bank1_dout,
   // read return
   output logic [banked_scratchpad_pkg::DATA_W-1:0]   rdata,       // data of last read
   output logic                                       rvalid       // one pulse per read
);

   localparam int SEL_W = banked_scratchpad_pkg::BANK_SEL_W;     // bank select bits
   localparam int AW    = banked_scratchpad_pkg::ADDR_W;         // host address bits

   logic bank_sel;     // bank of the current access
   logic rd_req;       // read accepted this cycle
   logic rd_pend_q;    // read issued last edge, data now at bank output
   logic rd_bank_q;    // bank holding the most recent read word

   // address split, low bit picks the bank
   assign bank_sel  = addr[0];
   assign bank_addr = addr[AW-1:SEL_W];     // upper bits index inside the bank

   // exactly one bank enabled per access
   assign bank0_ce = ce & ~bank_sel;
   assign bank1_ce = ce &  bank_sel;

   // read accept, writes never raise the strobe
   assign rd_req = ce & ~we;

   // strobe stage, matches the bank output register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_pend_q <= 1'b0;                 // nothing in flight after reset
      end else begin
         rd_pend_q <= rd_req;               // single cycle pulse per read
      end
   end

   // bank tag, follows reads only
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_bank_q <= 1'b0;                 // point at bank 0 after reset
      end else if (rd_req) begin
         rd_bank_q <= bank_sel;             // writes and idles leave it alone
      end
   end

   // read data steering from the tagged bank
   always_comb begin
      case (rd_bank_q)
         1'b0:    rdata = bank0_dout;
         1'b1:    rdata = bank1_dout;
         default: rdata = bank0_dout;
      endcase
   end

   assign rvalid = rd_pend_q;               // data and strobe line up

endmodule

//--- hw/sp_ram/sp_ram.sv
/*
 * sp_ram: single-port RAM bank with per-bit write mask
 * Async array lookup, optionally captured into an output register on ce.
 */

`timescale 1ns/10ps

module sp_ram #(
   parameter int DW    = 32,       // word width
   parameter int DEPTH = 64,       // number of words
   parameter int REG   = 1         // 1 = registered dout, 0 = raw lookup
) (
   input  logic                     clk,
   input  logic                     ce,     // chip enable
   input  logic                     we,     // write enable, needs ce
   input  logic [DW-1:0]            wmask,  // per bit write mask
   input  logic [$clog2(DEPTH)-1:0] addr,   // word address
   input  logic [DW-1:0]            din,    // write data
   output logic [DW-1:0]            dout    // read data
);

   localparam int AW = $clog2(DEPTH);      // address width from depth

   logic [DW-1:0] mem [0:DEPTH-1];          // storage array
   logic [DW-1:0] rd_word;                  // async lookup at addr
   logic [DW-1:0] wr_word;                  // masked merge of din into old word

   // async read of the addressed word
   assign rd_word = mem[addr[AW-1:0]];

   // merge new bits under the mask with the bits already stored
   always_comb begin
      for (int i = 0; i < DW; i++) begin
         wr_word[i] = wmask[i] ? din[i] : rd_word[i];   // keep old bit when unmasked
      end
   end

   // write port
   always_ff @(posedge clk) begin
      if (ce && we) begin
         mem[addr[AW-1:0]] <= wr_word;     // unmasked bits rewritten unchanged
      end
   end

   // read port, register or pass-through
   generate
      if (REG == 1) begin : g_out_reg
         logic [DW-1:0] rd_reg;            // output register

         always_ff @(posedge clk) begin
            if (ce) begin
               rd_reg <= rd_word;          // write cycles capture the old word
            end
         end

         assign dout = rd_reg;             // holds until next ce
      end else begin : g_out_raw
         assign dout = rd_word;            // follows addr same cycle
      end
   endgenerate

endmodule

//--- common/banked_scratchpad_pkg.sv
/*
 * Banked scratchpad shared constants
 * Word width, bank geometry and host address layout for the two-bank memory.
 */

package banked_scratchpad_pkg;

   // word and mask geometry
   localparam int DATA_W     = 32;                   // bits per memory word
                                                     // wmask is the same width

   // bank geometry
   localparam int BANK_DEPTH = 64;                   // words held by one bank
   localparam int BANK_AW    = $clog2(BANK_DEPTH);   // in-bank word address, 6 bits

   // interleave across banks
   localparam int NUM_BANKS  = 2;                    // even words bank 0, odd words bank 1
   localparam int BANK_SEL_W = $clog2(NUM_BANKS);    // one select bit at addr[0]

   // host address is the bank select below the in-bank address
   localparam int ADDR_W     = BANK_AW + BANK_SEL_W; // 7 bit host word address

   // read path
   localparam int RAM_REG    = 1;                    // bank output register on
                                                     // one cycle read latency

endpackage
